/* verilog/stereo_pkg.sv */
`default_nettype none

package stereo_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int cam_word_w  = 64;
    localparam int half_word_w = 32;
    localparam int frame_cnt_w = 16;
    localparam int wb_addr_w   = 2;
    localparam int wb_data_w   = 32;

    // ------------------------------
    // register map and commands
    // ------------------------------
    localparam logic [wb_addr_w-1:0] reg_cmd         = 2'd0;
    localparam logic [wb_addr_w-1:0] reg_frame_words = 2'd1;
    localparam logic [wb_addr_w-1:0] reg_status      = 2'd2;

    localparam logic [wb_data_w-1:0] cmd_start = 32'h1;
    localparam logic [wb_data_w-1:0] cmd_stop  = 32'h2;

    // one beat of the merged stereo stream
    typedef struct packed {
        logic [cam_word_w-1:0] data;
        logic                  last;
    } merged_beat_t;

    // registers to datapath
    typedef struct packed {
        logic                   running;
        logic [frame_cnt_w-1:0] frame_words;
    } stream_ctrl_t;

    // datapath to registers
    typedef struct packed {
        logic frame_done;
    } stream_status_t;

endpackage

`default_nettype wire

/* verilog/stereo_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module stereo_regs
    import stereo_pkg::*;
(
    input  logic                 fclk,
    input  logic                 rst_n,

    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [wb_addr_w-1:0] wb_adr,
    input  logic [wb_data_w-1:0] wb_dat_w,
    output logic [wb_data_w-1:0] wb_dat_r,
    output logic                 wb_ack,

    output stream_ctrl_t         ctrl,
    input  stream_status_t       status
);

    logic                   running;
    logic [frame_cnt_w-1:0] frame_words;
    logic [frame_cnt_w-1:0] frame_cnt;
    logic                   req;
    logic                   wr_en;
    logic [wb_data_w-1:0]   rd_data;

    // one access per strobe, ack blocks a second one
    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = req && wb_we;

    // ------------------------------
    // bus handshake
    // ------------------------------
    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;
        end
    end

    always_comb begin
        case (wb_adr)
            reg_cmd:         rd_data = '0;
            reg_frame_words: rd_data = {{(wb_data_w-frame_cnt_w){1'b0}}, frame_words};
            reg_status:      rd_data = {frame_cnt, 15'b0, running};
            default:         rd_data = '0;
        endcase
    end

    always_ff @(posedge fclk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    // ------------------------------
    // control registers
    // ------------------------------
    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            running     <= 1'b0;
            frame_words <= frame_cnt_w'(4);
        end else if (wr_en) begin
            if (wb_adr == reg_cmd) begin
                // unknown codes leave running alone
                if (wb_dat_w == cmd_start) begin
                    running <= 1'b1;
                end else if (wb_dat_w == cmd_stop) begin
                    running <= 1'b0;
                end
            end
            if (wb_adr == reg_frame_words) begin
                if (wb_dat_w[frame_cnt_w-1:0] == '0) begin
                    frame_words <= frame_cnt_w'(1);
                end else begin
                    frame_words <= wb_dat_w[frame_cnt_w-1:0];
                end
            end
        end
    end

    // completed frames, kept across stop
    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else if (status.frame_done) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

    assign ctrl.running     = running;
    assign ctrl.frame_words = frame_words;

endmodule

`default_nettype wire

/* verilog/word_serializer.sv */
`timescale 1ns/1ps
`default_nettype none

module word_serializer
    import stereo_pkg::*;
(
    input  logic                   fclk,
    input  logic                   rst_n,

    input  logic                   running,

    input  logic                   in_valid,
    output logic                   in_ready,
    input  logic [cam_word_w-1:0]  in_data,

    output logic                   out_valid,
    input  logic                   out_ready,
    output logic [half_word_w-1:0] out_data
);

    logic [cam_word_w-1:0] word_q;
    logic                  full;
    logic                  hi_half;
    logic                  in_xfer;
    logic                  out_xfer;

    assign out_xfer = out_valid && out_ready;

    // refill while the high half leaves
    assign in_ready = running && (!full || (hi_half && out_ready));
    assign in_xfer  = in_valid && in_ready;

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            full    <= 1'b0;
            hi_half <= 1'b0;
        end else if (in_xfer) begin
            full    <= 1'b1;
            hi_half <= 1'b0;
        end else if (out_xfer) begin
            full    <= !hi_half;
            hi_half <= !hi_half;
        end
    end

    always_ff @(posedge fclk) begin
        if (in_xfer) begin
            word_q <= in_data;
        end
    end

    // low half goes first
    assign out_valid = full;
    assign out_data  = hi_half ? word_q[cam_word_w-1:half_word_w] : word_q[half_word_w-1:0];

endmodule

`default_nettype wire

/* verilog/stereo_interleaver.sv */
`timescale 1ns/1ps
`default_nettype none

module stereo_interleaver
    import stereo_pkg::*;
(
    input  logic                   fclk,
    input  logic                   rst_n,

    input  logic [frame_cnt_w-1:0] frame_words,

    input  logic                   a_valid,
    output logic                   a_ready,
    input  logic [half_word_w-1:0] a_data,

    input  logic                   b_valid,
    output logic                   b_ready,
    input  logic [half_word_w-1:0] b_data,

    output logic                   out_valid,
    input  logic                   out_ready,
    output merged_beat_t           out_beat,

    output stream_status_t         status
);

    logic                   valid_q;
    merged_beat_t           beat_q;
    logic                   done_q;
    logic [frame_cnt_w-1:0] word_cnt;
    logic                   take;
    logic                   is_last;
    logic [cam_word_w-1:0]  merged_data;

    // both sides move together
    assign take    = a_valid && b_valid && (!valid_q || out_ready);
    assign a_ready = take;
    assign b_ready = take;

    // >= so a shortened frame length still closes the frame
    assign is_last = (word_cnt >= frame_words);

    // a byte above b byte, msb first
    always_comb begin
        merged_data = '0;
        for (int i = 0; i < half_word_w / 8; i++) begin
            merged_data[16*i+8 +: 8] = a_data[8*i +: 8];
            merged_data[16*i   +: 8] = b_data[8*i +: 8];
        end
    end

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            valid_q  <= 1'b0;
            done_q   <= 1'b0;
            word_cnt <= frame_cnt_w'(1);
        end else begin
            done_q <= take && is_last;
            if (take) begin
                valid_q  <= 1'b1;
                word_cnt <= is_last ? frame_cnt_w'(1) : word_cnt + 1'b1;
            end else if (out_ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge fclk) begin
        if (take) begin
            beat_q.data <= merged_data;
            beat_q.last <= is_last;
        end
    end

    assign out_valid         = valid_q;
    assign out_beat          = beat_q;
    assign status.frame_done = done_q;

endmodule

`default_nettype wire

/* verilog/out_skid_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module out_skid_buffer
    import stereo_pkg::*;
(
    input  logic                  fclk,
    input  logic                  rst_n,

    input  logic                  in_valid,
    output logic                  in_ready,
    input  merged_beat_t          in_beat,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [cam_word_w-1:0] out_data,
    output logic                  out_last
);

    logic         main_valid;
    logic         skid_valid;
    merged_beat_t main_beat;
    merged_beat_t skid_beat;
    logic         push;
    logic         load_main;

    // registered ready, only the skid slot decides
    assign in_ready  = !skid_valid;
    assign push      = in_valid && in_ready;
    assign load_main = !main_valid || out_ready;

    always_ff @(posedge fclk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_main) begin
            main_valid <= skid_valid || push;
            skid_valid <= 1'b0;
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    // older beat in skid goes out first
    always_ff @(posedge fclk) begin
        if (load_main) begin
            main_beat <= skid_valid ? skid_beat : in_beat;
        end else if (push) begin
            skid_beat <= in_beat;
        end
    end

    assign out_valid = main_valid;
    assign out_data  = main_beat.data;
    assign out_last  = main_beat.last;

endmodule

`default_nettype wire

/* verilog/stereo_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stereo_top
    import stereo_pkg::*;
(
    input  logic                  fclk,
    input  logic                  rst_n,

    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_we,
    input  logic [wb_addr_w-1:0]  wb_adr,
    input  logic [wb_data_w-1:0]  wb_dat_w,
    output logic [wb_data_w-1:0]  wb_dat_r,
    output logic                  wb_ack,

    input  logic                  cam0_valid,
    output logic                  cam0_ready,
    input  logic [cam_word_w-1:0] cam0_data,

    input  logic                  cam1_valid,
    output logic                  cam1_ready,
    input  logic [cam_word_w-1:0] cam1_data,

    output logic                  out_valid,
    input  logic                  out_ready,
    output logic [cam_word_w-1:0] out_data,
    output logic                  out_last
);

    stream_ctrl_t           ctrl;
    stream_status_t         status;

    logic                   ser0_valid;
    logic                   ser0_ready;
    logic [half_word_w-1:0] ser0_data;
    logic                   ser1_valid;
    logic                   ser1_ready;
    logic [half_word_w-1:0] ser1_data;

    logic                   merged_valid;
    logic                   merged_ready;
    merged_beat_t           merged_beat;

    // ------------------------------
    // control
    // ------------------------------
    stereo_regs regs_inst (
        .fclk     (fclk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ctrl     (ctrl),
        .status   (status)
    );

    // ------------------------------
    // input side, one per camera
    // ------------------------------
    word_serializer ser_cam0 (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .running   (ctrl.running),
        .in_valid  (cam0_valid),
        .in_ready  (cam0_ready),
        .in_data   (cam0_data),
        .out_valid (ser0_valid),
        .out_ready (ser0_ready),
        .out_data  (ser0_data)
    );

    word_serializer ser_cam1 (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .running   (ctrl.running),
        .in_valid  (cam1_valid),
        .in_ready  (cam1_ready),
        .in_data   (cam1_data),
        .out_valid (ser1_valid),
        .out_ready (ser1_ready),
        .out_data  (ser1_data)
    );

    // ------------------------------
    // merge and output
    // ------------------------------
    stereo_interleaver interleaver_inst (
        .fclk        (fclk),
        .rst_n       (rst_n),
        .frame_words (ctrl.frame_words),
        .a_valid     (ser0_valid),
        .a_ready     (ser0_ready),
        .a_data      (ser0_data),
        .b_valid     (ser1_valid),
        .b_ready     (ser1_ready),
        .b_data      (ser1_data),
        .out_valid   (merged_valid),
        .out_ready   (merged_ready),
        .out_beat    (merged_beat),
        .status      (status)
    );

    out_skid_buffer skid_inst (
        .fclk      (fclk),
        .rst_n     (rst_n),
        .in_valid  (merged_valid),
        .in_ready  (merged_ready),
        .in_beat   (merged_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_last  (out_last)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic fclk,
    output logic rst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 5;

    initial begin
        fclk = 1'b0;
        forever #(half_period) fclk = ~fclk;
    end

    // release on a rising edge, reset is synchronous
    initial begin
        rst_n <= 1'b0;
        repeat (reset_cycles) @(posedge fclk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/stereo_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module stereo_top_tb
    import stereo_pkg::*;
();

    localparam int ack_timeout   = 20;
    localparam int drain_timeout = 400;

    logic                   fclk;
    logic                   rst_n;
    logic                   wb_cyc     = 1'b0;
    logic                   wb_stb     = 1'b0;
    logic                   wb_we      = 1'b0;
    logic [wb_addr_w-1:0]   wb_adr     = '0;
    logic [wb_data_w-1:0]   wb_dat_w   = '0;
    logic [wb_data_w-1:0]   wb_dat_r;
    logic                   wb_ack;
    logic                   cam0_valid = 1'b0;
    logic                   cam0_ready;
    logic [cam_word_w-1:0]  cam0_data  = '0;
    logic                   cam1_valid = 1'b0;
    logic                   cam1_ready;
    logic [cam_word_w-1:0]  cam1_data  = '0;
    logic                   out_valid;
    logic                   out_ready  = 1'b0;
    logic [cam_word_w-1:0]  out_data;
    logic                   out_last;

    int gap_pct   = 0;
    int ready_pct = 100;
    int err_cnt   = 0;
    int check_cnt = 0;
    int beats_seen  = 0;
    int frames_seen = 0;
    int acc0 = 0;
    int acc1 = 0;
    int frame_len = 4;
    int frame_pos = 1;
    logic high_half = 1'b0;
    logic [cam_word_w-1:0] cam0_q[$];
    logic [cam_word_w-1:0] cam1_q[$];

    tb_clk_gen clk_gen_inst (
        .fclk  (fclk),
        .rst_n (rst_n)
    );

    stereo_top stereo_top_inst (
        .fclk       (fclk),
        .rst_n      (rst_n),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .cam0_valid (cam0_valid),
        .cam0_ready (cam0_ready),
        .cam0_data  (cam0_data),
        .cam1_valid (cam1_valid),
        .cam1_ready (cam1_ready),
        .cam1_data  (cam1_data),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last)
    );

    // ------------------------------
    // reference and checks
    // ------------------------------
    // low half first, then a and b bytes alternate from the msb down
    function automatic logic [cam_word_w-1:0] merge_ref(input logic [cam_word_w-1:0] word0,
                                                      input logic [cam_word_w-1:0] word1,
                                                      input logic high);
        logic [half_word_w-1:0] a;
        logic [half_word_w-1:0] b;
        a = high ? word0[63:32] : word0[31:0];
        b = high ? word1[63:32] : word1[31:0];
        return {a[31:24], b[31:24], a[23:16], b[23:16], a[15:8], b[15:8], a[7:0], b[7:0]};
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] expected);
        check_cnt++;
        if (got !== expected) begin
            err_cnt++;
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ------------------------------
    // stimulus sources
    // ------------------------------
    always @(posedge fclk) begin
        if (!rst_n) begin
            cam0_valid <= 1'b0;
        end else if (!cam0_valid || cam0_ready) begin
            if (($urandom % 100) >= gap_pct) begin
                cam0_valid <= 1'b1;
                cam0_data  <= {$urandom, $urandom};
            end else begin
                cam0_valid <= 1'b0;
            end
        end
    end

    always @(posedge fclk) begin
        if (!rst_n) begin
            cam1_valid <= 1'b0;
        end else if (!cam1_valid || cam1_ready) begin
            if (($urandom % 100) >= gap_pct) begin
                cam1_valid <= 1'b1;
                cam1_data  <= {$urandom, $urandom};
            end else begin
                cam1_valid <= 1'b0;
            end
        end
    end

    always @(posedge fclk) begin
        if (!rst_n) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= (($urandom % 100) < ready_pct);
        end
    end

    // compare first, then queue this edge's camera words
    always @(posedge fclk) begin : compare_proc
        logic exp_last;
        if (rst_n && out_valid && out_ready) begin
            if (cam0_q.size() == 0 || cam1_q.size() == 0) begin
                err_cnt++;
                $display("output beat at %0t arrived with no camera word behind it", $time);
            end else begin
                exp_last = (frame_pos == frame_len);
                check_value("out_data", out_data, merge_ref(cam0_q[0], cam1_q[0], high_half));
                check_value("out_last", 64'(out_last), 64'(exp_last));
                if (exp_last) begin
                    frames_seen++;
                    frame_pos = 1;
                end else begin
                    frame_pos++;
                end
                if (high_half) begin
                    void'(cam0_q.pop_front());
                    void'(cam1_q.pop_front());
                end
                high_half = !high_half;
            end
            beats_seen++;
        end
        if (rst_n && cam0_valid && cam0_ready) begin
            cam0_q.push_back(cam0_data);
            acc0++;
        end
        if (rst_n && cam1_valid && cam1_ready) begin
            cam1_q.push_back(cam1_data);
            acc1++;
        end
    end

    // ------------------------------
    // bus and wait helpers
    // ------------------------------
    task automatic wb_access(input logic we, input logic [wb_addr_w-1:0] adr,
                             input logic [wb_data_w-1:0] wdata,
                             output logic [wb_data_w-1:0] rdata);
        int n;
        @(posedge fclk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        n = 0;
        do begin
            @(posedge fclk);
            n++;
        end while (!wb_ack && n < ack_timeout);
        if (!wb_ack) begin
            err_cnt++;
            $display("wishbone access to address %0d got no acknowledge", adr);
        end
        rdata = wb_dat_r;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic reg_write(input logic [wb_addr_w-1:0] adr, input logic [wb_data_w-1:0] data);
        logic [wb_data_w-1:0] unused_rd;
        wb_access(1'b1, adr, data, unused_rd);
    endtask

    task automatic reg_read(input logic [wb_addr_w-1:0] adr, output logic [wb_data_w-1:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic wait_beats(input int target, input int limit);
        int n;
        n = 0;
        while (beats_seen < target && n < limit) begin
            @(posedge fclk);
            n++;
        end
        if (beats_seen < target) begin
            err_cnt++;
            $display("timed out with %0d of %0d output beats received", beats_seen, target);
        end
    endtask

    // stop, let held halves drain, then expect silence
    task automatic stop_and_drain();
        int n;
        int beats_before;
        logic [wb_data_w-1:0] rd;
        reg_write(reg_cmd, cmd_stop);
        n = 0;
        while (beats_seen != 2 * ((acc0 < acc1) ? acc0 : acc1) && n < drain_timeout) begin
            @(posedge fclk);
            n++;
        end
        if (beats_seen != 2 * ((acc0 < acc1) ? acc0 : acc1)) begin
            err_cnt++;
            $display("accepted camera words did not drain after stop");
        end
        beats_before = beats_seen;
        repeat (50) begin
            @(posedge fclk);
            check_value("cam0_ready while stopped", 64'(cam0_ready), 64'd0);
            check_value("cam1_ready while stopped", 64'(cam1_ready), 64'd0);
        end
        check_value("beats after drain", 64'(beats_seen), 64'(beats_before));
        reg_read(reg_status, rd);
        check_value("status running", 64'(rd[0]), 64'd0);
        check_value("status frames", 64'(rd[31:16]), 64'(frames_seen));
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------
    initial begin : main_proc
        int n;
        logic [wb_data_w-1:0] rd;
        void'($urandom(32'h4406_ff33));
        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            @(posedge fclk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            err_cnt++;
            $display("reset was never released");
        end

        repeat (20) begin
            @(posedge fclk);
            check_value("cam0_ready after reset", 64'(cam0_ready), 64'd0);
            check_value("cam1_ready after reset", 64'(cam1_ready), 64'd0);
            check_value("out_valid after reset", 64'(out_valid), 64'd0);
        end
        reg_read(reg_status, rd);
        check_value("status after reset", 64'(rd), 64'd0);

        // steady streams
        reg_write(reg_cmd, cmd_start);
        wait_beats(16, 200);

        // random gaps and back-pressure
        gap_pct   <= 30;
        ready_pct <= 60;
        wait_beats(beats_seen + 200, 3000);

        stop_and_drain();

        // frame length 5 and a restart on the queued words
        reg_write(reg_frame_words, 32'd5);
        frame_len = 5;
        reg_read(reg_frame_words, rd);
        check_value("frame_words readback", 64'(rd), 64'd5);
        reg_write(reg_cmd, cmd_start);
        wait_beats(beats_seen + 20, 600);
        stop_and_drain();

        reg_write(reg_frame_words, 32'd0);
        frame_len = 1;
        reg_read(reg_frame_words, rd);
        check_value("frame_words zero readback", 64'(rd), 64'd1);

        $display("checks %0d, errors %0d, beats %0d, frames %0d",
                 check_cnt, err_cnt, beats_seen, frames_seen);
        if (err_cnt == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* stereo_top.f */
verilog/stereo_pkg.sv
verilog/stereo_regs.sv
verilog/word_serializer.sv
verilog/stereo_interleaver.sv
verilog/out_skid_buffer.sv
verilog/stereo_top.sv
dv/tb_clk_gen.sv
dv/stereo_top_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module stereo_top_tb \
        -f stereo_top.f -o stereo_sim \
    && ./obj_dir/stereo_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
